/* Makefile */
TOOL     = verilator
FLAGS    = --binary --timing
TOP      = tb_roce_tx_top
FILELIST = roce_tx_top.f
LOG      = sim.log
PASS_MSG = Test completed successfully

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

lint:
	$(TOOL) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf obj_dir $(LOG)

/* common/roce_consts.svh */
`ifndef ROCE_CONSTS_SVH
`define ROCE_CONSTS_SVH

`define NUM_QP             4
`define NUM_SEND_PKT       8
`define NUM_RD_PKT         8
`define NUM_WR_PKT         8
`define BEAT_BYTES         64

`define SEND_PAYLOAD_BYTES 80
`define RD_PAYLOAD_BYTES   256
`define SEND_PKT_BYTES     134  // wire bytes, icrc not included
`define RD_PKT_BYTES       314
`define ACK_PKT_BYTES      58

// ipv4 total lengths count the 4-byte icrc
`define SEND_TOTAL_LEN     16'h007c
`define RD_TOTAL_LEN       16'h0130
`define ACK_TOTAL_LEN      16'h0030

`define OP_SEND_ONLY       8'h04
`define OP_RD_RESP_ONLY    8'h10
`define OP_ACK             8'h11
`define SEND_BTH_FLAGS     8'h30
`define BTH_PKEY           16'h666f
`define BTH_RSVD           8'h05

`define ETHERTYPE_IPV4     16'h0800
`define IP_VER_IHL         8'h45
`define IP_TOS             8'hb8
`define IP_IDENT           16'h5555
`define IP_FLAGS           16'h4000
`define IP_TTL             8'hba
`define IP_PROTO_UDP       8'h11
`define UDP_SRC_PORT       16'h6851
`define UDP_DST_PORT       16'h12b7
`define UDP_CSUM           16'h0000

`endif

/* common/roce_hdr_pkg.sv */
`include "roce_consts.svh"

package roce_hdr_pkg;

  typedef struct packed {
    logic [47:0] dst_mac;
    logic [47:0] src_mac;
    logic [15:0] ethertype;
  } eth_hdr_t;

  typedef struct packed {
    logic [7:0]  ver_ihl;
    logic [7:0]  tos;
    logic [15:0] total_len;
    logic [15:0] ident;
    logic [15:0] flags_frag;
    logic [7:0]  ttl;
    logic [7:0]  protocol;
    logic [15:0] checksum;
    logic [31:0] src_ip;
    logic [31:0] dst_ip;
  } ipv4_hdr_t;

  typedef struct packed {
    logic [15:0] src_port;
    logic [15:0] dst_port;
    logic [15:0] length;
    logic [15:0] checksum;
  } udp_hdr_t;

  typedef struct packed {
    logic [7:0]  opcode;
    logic [7:0]  flags;    // se, m, pad count, tver
    logic [15:0] pkey;
    logic [7:0]  rsvd;
    logic [23:0] dest_qp;
    logic [7:0]  ack_req;
    logic [23:0] psn;
  } bth_t;

  typedef struct packed {
    logic [7:0]  syndrome;
    logic [23:0] msn;
  } aeth_t;

  // eth + ipv4 + udp + bth, 54 bytes
  typedef struct packed {
    eth_hdr_t  eth;
    ipv4_hdr_t ip;
    udp_hdr_t  udp;
    bth_t      bth;
  } base_hdr_t;

  typedef struct packed {
    base_hdr_t                            hdr;
    logic [`SEND_PAYLOAD_BYTES-1:0][7:0] payload;
  } send_img_t;

  // ack uses only the first 58 bytes
  typedef struct packed {
    base_hdr_t                          hdr;
    aeth_t                              aeth;
    logic [`RD_PAYLOAD_BYTES-1:0][7:0] payload;
  } resp_img_t;

  function automatic logic [15:0] ipv4_checksum(input ipv4_hdr_t hdr);
    ipv4_hdr_t   tmp;
    logic [19:0] sum;
    tmp          = hdr;
    tmp.checksum = '0;
    sum          = '0;
    for (int i = 0; i < 10; i++) begin
      sum = sum + 20'(tmp[i*16 +: 16]);
    end
    sum = 20'(sum[15:0]) + 20'(sum[19:16]); // fold carries twice
    sum = 20'(sum[15:0]) + 20'(sum[19:16]);
    return ~sum[15:0];
  endfunction

  function automatic base_hdr_t make_hdr(
    input logic [47:0] mac_d,
    input logic [47:0] mac_s,
    input logic [31:0] ip_s,
    input logic [31:0] ip_d,
    input logic [15:0] ip_len,
    input logic [7:0]  op,
    input logic [7:0]  bth_flags,
    input logic [23:0] qpn,
    input logic [23:0] seq
  );
    base_hdr_t h;
    h.eth = '{dst_mac: mac_d, src_mac: mac_s, ethertype: `ETHERTYPE_IPV4};
    h.ip  = '{ver_ihl: `IP_VER_IHL, tos: `IP_TOS, total_len: ip_len, ident: `IP_IDENT,
              flags_frag: `IP_FLAGS, ttl: `IP_TTL, protocol: `IP_PROTO_UDP,
              checksum: 16'h0000, src_ip: ip_s, dst_ip: ip_d};
    h.ip.checksum = ipv4_checksum(h.ip);
    h.udp = '{src_port: `UDP_SRC_PORT, dst_port: `UDP_DST_PORT,
              length: ip_len - 16'd20, checksum: `UDP_CSUM};
    h.bth = '{opcode: op, flags: bth_flags, pkey: `BTH_PKEY, rsvd: `BTH_RSVD,
              dest_qp: qpn, ack_req: 8'h00, psn: seq};
    return h;
  endfunction

endpackage

/* common/tx_stream_pkg.sv */
`include "roce_consts.svh"

package tx_stream_pkg;

  typedef struct packed {
    logic [`BEAT_BYTES*8-1:0] data;  // byte 0 in [7:0]
    logic [`BEAT_BYTES-1:0]   keep;
    logic                     last;
  } tx_beat_t;

  typedef struct packed {
    logic [`BEAT_BYTES*8-1:0] data;
    logic                     last;
  } wqe_desc_t;

  typedef struct packed {
    logic [47:0] dst_mac;
    logic [31:0] dst_ip;
    logic [23:0] base_psn;
  } qp_entry_t;

  typedef struct packed {
    logic [47:0] src_mac;
    logic [31:0] src_ip;
  } local_cfg_t;

endpackage

/* pkt_gen/pkt_serializer.sv */
`include "roce_consts.svh"

module pkt_serializer #(
  parameter type img_t = logic [`BEAT_BYTES*8-1:0]
) (
  input  logic                    core_clk,
  input  logic                    core_aresetn,
  input  logic                    load_i,
  input  img_t                    img_i,
  input  logic [15:0]             len_i,
  output tx_stream_pkg::tx_beat_t beat_o,
  output logic                    valid_o,
  input  logic                    ready_i,
  output logic                    done_o
);

  localparam int IMG_BYTES = $bits(img_t) / 8;
  localparam int NUM_BEATS = (IMG_BYTES + `BEAT_BYTES - 1) / `BEAT_BYTES;
  localparam int BUF_W     = NUM_BEATS * `BEAT_BYTES * 8;
  localparam logic [`BEAT_BYTES-1:0] KEEP_ALL = '1;

  logic [IMG_BYTES*8-1:0] img_rev;
  logic [BUF_W-1:0]       buf_q;
  logic [15:0]            rem_q;  // bytes not yet transferred
  logic                   valid_q;
  logic                   xfer;

  // first header byte moves to the low end
  assign img_rev = {<<8{img_i}};
  assign xfer    = valid_q & ready_i;
  assign done_o  = xfer & beat_o.last;
  assign valid_o = valid_q;

  assign beat_o.data = buf_q[`BEAT_BYTES*8-1:0];
  assign beat_o.last = (rem_q <= 16'(`BEAT_BYTES));
  assign beat_o.keep = beat_o.last ? KEEP_ALL >> (`BEAT_BYTES - rem_q) : KEEP_ALL;

  always_ff @(posedge core_clk) begin
    if (load_i) begin
      buf_q <= BUF_W'(img_rev);
    end else if (xfer) begin
      buf_q <= buf_q >> (`BEAT_BYTES * 8);
    end
  end

  always_ff @(posedge core_clk or negedge core_aresetn) begin
    if (!core_aresetn) begin
      valid_q <= 1'b0;
      rem_q   <= '0;
    end else if (load_i) begin
      valid_q <= 1'b1;
      rem_q   <= len_i;
    end else if (xfer) begin
      valid_q <= ~beat_o.last;
      rem_q   <= rem_q - 16'(`BEAT_BYTES);
    end
  end

endmodule

/* pkt_gen/resp_pkt_gen.sv */
`include "roce_consts.svh"

module resp_pkt_gen (
  input  logic                      core_clk,
  input  logic                      core_aresetn,
  input  logic                      cfg_done_i,
  input  tx_stream_pkg::local_cfg_t local_cfg_i,
  input  tx_stream_pkg::qp_entry_t  qp_tbl_i [`NUM_QP],
  input  tx_stream_pkg::wqe_desc_t  wqe_desc_i,
  input  logic                      wqe_valid_i,
  output logic                      post_rd_wqe_o,
  output logic                      post_wr_wqe_o,
  output tx_stream_pkg::tx_beat_t   beat_o,
  output logic                      valid_o,
  input  logic                      ready_i,
  output logic                      rd_done_o,
  output logic                      wr_done_o
);
  import roce_hdr_pkg::*;
  import tx_stream_pkg::*;

  localparam int QP_W = $clog2(`NUM_QP);

  typedef enum logic [2:0] {
    S_IDLE, S_POST, S_WAIT_DESC, S_BUILD, S_WAIT_TX, S_DONE
  } state_t;

  state_t          state_q;
  logic            wr_phase_q;  // 0 read responses, 1 acks
  logic [7:0]      req_cnt_q;
  logic [7:0]      last_req;
  logic            load_q;
  logic            pkt_done;
  logic [23:0]     qpn_q;
  logic [23:0]     psn_q;
  logic [QP_W-1:0] qp_idx;
  qp_entry_t       qp;
  logic [7:0]      pay_byte;
  logic [15:0]     pkt_len;
  resp_img_t       img_d;
  resp_img_t       img_q;

  assign last_req = wr_phase_q ? 8'(`NUM_WR_PKT - 1) : 8'(`NUM_RD_PKT - 1);
  assign qp_idx   = QP_W'((qpn_q - 24'd2) % `NUM_QP);  // qp numbers start at 2
  assign qp       = qp_tbl_i[qp_idx];
  assign pay_byte = {4'h1, req_cnt_q[3:0] + 4'd1};
  assign pkt_len  = wr_phase_q ? 16'(`ACK_PKT_BYTES) : 16'(`RD_PKT_BYTES);

  always_comb begin
    img_d.aeth = '0;
    if (wr_phase_q) begin
      img_d.hdr     = make_hdr(qp.dst_mac, local_cfg_i.src_mac, local_cfg_i.src_ip,
                               qp.dst_ip, `ACK_TOTAL_LEN, `OP_ACK, 8'h00, qpn_q, psn_q);
      img_d.payload = '0;
    end else begin
      img_d.hdr     = make_hdr(qp.dst_mac, local_cfg_i.src_mac, local_cfg_i.src_ip,
                               qp.dst_ip, `RD_TOTAL_LEN, `OP_RD_RESP_ONLY, 8'h00,
                               qpn_q, psn_q);
      img_d.payload = {`RD_PAYLOAD_BYTES{pay_byte}};
    end
  end

  always_ff @(posedge core_clk) begin
    if (state_q == S_WAIT_DESC && wqe_valid_i) begin
      qpn_q <= {wqe_desc_i.data[47*8 +: 8], wqe_desc_i.data[48*8 +: 8],
                wqe_desc_i.data[49*8 +: 8]};
      psn_q <= {wqe_desc_i.data[51*8 +: 8], wqe_desc_i.data[52*8 +: 8],
                wqe_desc_i.data[53*8 +: 8]};
    end
    if (state_q == S_BUILD) begin
      img_q <= img_d;
    end
  end

  always_ff @(posedge core_clk or negedge core_aresetn) begin
    if (!core_aresetn) begin
      state_q       <= S_IDLE;
      wr_phase_q    <= 1'b0;
      req_cnt_q     <= '0;
      load_q        <= 1'b0;
      post_rd_wqe_o <= 1'b0;
      post_wr_wqe_o <= 1'b0;
      rd_done_o     <= 1'b0;
      wr_done_o     <= 1'b0;
    end else begin
      load_q        <= 1'b0;
      post_rd_wqe_o <= 1'b0;
      post_wr_wqe_o <= 1'b0;
      case (state_q)
        S_IDLE: begin
          if (cfg_done_i) state_q <= S_POST;
        end
        S_POST: begin
          post_rd_wqe_o <= ~wr_phase_q;
          post_wr_wqe_o <= wr_phase_q;
          state_q       <= S_WAIT_DESC;
        end
        S_WAIT_DESC: begin
          if (wqe_valid_i) state_q <= S_BUILD;
        end
        S_BUILD: begin
          load_q  <= 1'b1;
          state_q <= S_WAIT_TX;
        end
        S_WAIT_TX: begin
          if (pkt_done) begin
            if (req_cnt_q != last_req) begin
              req_cnt_q <= req_cnt_q + 8'd1;
              state_q   <= S_POST;
            end else if (!wr_phase_q) begin
              rd_done_o  <= 1'b1;  // reads finished, move on to writes
              wr_phase_q <= 1'b1;
              req_cnt_q  <= '0;
              state_q    <= S_POST;
            end else begin
              wr_done_o <= 1'b1;
              state_q   <= S_DONE;
            end
          end
        end
        default: state_q <= S_DONE;
      endcase
    end
  end

  pkt_serializer #(
    .img_t (resp_img_t)
  ) i_pkt_serializer (
    .core_clk     (core_clk),
    .core_aresetn (core_aresetn),
    .load_i       (load_q),
    .img_i        (img_q),
    .len_i        (pkt_len),
    .beat_o       (beat_o),
    .valid_o      (valid_o),
    .ready_i      (ready_i),
    .done_o       (pkt_done)
  );

endmodule

/* pkt_gen/send_pkt_gen.sv */
`include "roce_consts.svh"

module send_pkt_gen (
  input  logic                      core_clk,
  input  logic                      core_aresetn,
  input  logic                      cfg_done_i,
  input  tx_stream_pkg::local_cfg_t local_cfg_i,
  input  tx_stream_pkg::qp_entry_t  qp_tbl_i [`NUM_QP],
  output tx_stream_pkg::tx_beat_t   beat_o,
  output logic                      valid_o,
  input  logic                      ready_i,
  output logic                      send_done_o
);
  import roce_hdr_pkg::*;
  import tx_stream_pkg::*;

  localparam int CNT_W = $clog2(`NUM_SEND_PKT);
  localparam int QP_W  = $clog2(`NUM_QP);

  typedef enum logic [1:0] {S_IDLE, S_BUILD, S_WAIT_TX, S_DONE} state_t;

  state_t           state_q;
  logic [CNT_W-1:0] pkt_cnt_q;
  logic             load_q;
  logic             pkt_done;
  logic [QP_W-1:0]  qp_idx;
  qp_entry_t        qp;
  logic [23:0]      psn;
  logic [7:0]       pay_byte;
  send_img_t        img_d;
  send_img_t        img_q;

  assign qp_idx   = QP_W'(pkt_cnt_q % `NUM_QP);  // round robin over the table
  assign qp       = qp_tbl_i[qp_idx];
  assign psn      = qp.base_psn + 24'(pkt_cnt_q / `NUM_QP) + 24'd1;
  assign pay_byte = 8'(pkt_cnt_q) + 8'd1;

  always_comb begin
    img_d.hdr     = make_hdr(qp.dst_mac, local_cfg_i.src_mac, local_cfg_i.src_ip, qp.dst_ip,
                             `SEND_TOTAL_LEN, `OP_SEND_ONLY, `SEND_BTH_FLAGS,
                             24'(qp_idx) + 24'd2, psn);
    img_d.payload = {`SEND_PAYLOAD_BYTES{pay_byte}};
  end

  always_ff @(posedge core_clk) begin
    if (state_q == S_BUILD) begin
      img_q <= img_d;
    end
  end

  always_ff @(posedge core_clk or negedge core_aresetn) begin
    if (!core_aresetn) begin
      state_q     <= S_IDLE;
      pkt_cnt_q   <= '0;
      load_q      <= 1'b0;
      send_done_o <= 1'b0;
    end else begin
      load_q <= 1'b0;
      case (state_q)
        S_IDLE: begin
          if (cfg_done_i) state_q <= S_BUILD;
        end
        S_BUILD: begin
          load_q  <= 1'b1;  // image is in img_q next cycle
          state_q <= S_WAIT_TX;
        end
        S_WAIT_TX: begin
          if (pkt_done) begin
            if (pkt_cnt_q == CNT_W'(`NUM_SEND_PKT - 1)) begin
              send_done_o <= 1'b1;
              state_q     <= S_DONE;
            end else begin
              pkt_cnt_q <= pkt_cnt_q + 1'b1;
              state_q   <= S_BUILD;
            end
          end
        end
        default: state_q <= S_DONE;
      endcase
    end
  end

  pkt_serializer #(
    .img_t (send_img_t)
  ) i_pkt_serializer (
    .core_clk     (core_clk),
    .core_aresetn (core_aresetn),
    .load_i       (load_q),
    .img_i        (img_q),
    .len_i        (16'(`SEND_PKT_BYTES)),
    .beat_o       (beat_o),
    .valid_o      (valid_o),
    .ready_i      (ready_i),
    .done_o       (pkt_done)
  );

endmodule

/* roce_tx_top.f */
+incdir+common
common/tx_stream_pkg.sv
common/roce_hdr_pkg.sv
pkt_gen/pkt_serializer.sv
pkt_gen/send_pkt_gen.sv
pkt_gen/resp_pkt_gen.sv
src/tx_stream_arbiter.sv
src/roce_tx_top.sv
test/tb_clk_gen.sv
test/tb_pkt_checker.sv
test/tb_roce_tx_top.sv

/* src/roce_tx_top.sv */
`include "roce_consts.svh"

module roce_tx_top (
  input  logic                      core_clk,
  input  logic                      core_aresetn,
  input  logic                      cfg_done_i,
  input  tx_stream_pkg::local_cfg_t local_cfg_i,
  input  tx_stream_pkg::qp_entry_t  qp_tbl_i [`NUM_QP],
  input  tx_stream_pkg::wqe_desc_t  wqe_desc_i,
  input  logic                      wqe_valid_i,
  output tx_stream_pkg::tx_beat_t   tx_beat_o,
  output logic                      tx_valid_o,
  input  logic                      tx_ready_i,
  output logic                      post_rd_wqe_o,
  output logic                      post_wr_wqe_o,
  output logic                      send_done_o,
  output logic                      rd_done_o,
  output logic                      wr_done_o
);
  import tx_stream_pkg::*;

  tx_beat_t send_beat;
  logic     send_valid;
  logic     send_ready;
  tx_beat_t resp_beat;
  logic     resp_valid;
  logic     resp_ready;

  send_pkt_gen i_send_pkt_gen (
    .core_clk     (core_clk),
    .core_aresetn (core_aresetn),
    .cfg_done_i   (cfg_done_i),
    .local_cfg_i  (local_cfg_i),
    .qp_tbl_i     (qp_tbl_i),
    .beat_o       (send_beat),
    .valid_o      (send_valid),
    .ready_i      (send_ready),
    .send_done_o  (send_done_o)
  );

  resp_pkt_gen i_resp_pkt_gen (
    .core_clk      (core_clk),
    .core_aresetn  (core_aresetn),
    .cfg_done_i    (cfg_done_i),
    .local_cfg_i   (local_cfg_i),
    .qp_tbl_i      (qp_tbl_i),
    .wqe_desc_i    (wqe_desc_i),
    .wqe_valid_i   (wqe_valid_i),
    .post_rd_wqe_o (post_rd_wqe_o),
    .post_wr_wqe_o (post_wr_wqe_o),
    .beat_o        (resp_beat),
    .valid_o       (resp_valid),
    .ready_i       (resp_ready),
    .rd_done_o     (rd_done_o),
    .wr_done_o     (wr_done_o)
  );

  // send traffic on port a, responses on port b
  tx_stream_arbiter i_tx_stream_arbiter (
    .core_clk     (core_clk),
    .core_aresetn (core_aresetn),
    .a_beat_i     (send_beat),
    .a_valid_i    (send_valid),
    .a_ready_o    (send_ready),
    .b_beat_i     (resp_beat),
    .b_valid_i    (resp_valid),
    .b_ready_o    (resp_ready),
    .beat_o       (tx_beat_o),
    .valid_o      (tx_valid_o),
    .ready_i      (tx_ready_i)
  );

endmodule

/* src/tx_stream_arbiter.sv */
module tx_stream_arbiter (
  input  logic                    core_clk,
  input  logic                    core_aresetn,
  input  tx_stream_pkg::tx_beat_t a_beat_i,
  input  logic                    a_valid_i,
  output logic                    a_ready_o,
  input  tx_stream_pkg::tx_beat_t b_beat_i,
  input  logic                    b_valid_i,
  output logic                    b_ready_o,
  output tx_stream_pkg::tx_beat_t beat_o,
  output logic                    valid_o,
  input  logic                    ready_i
);

  logic grant_q;     // 0 port a, 1 port b
  logic busy_q;      // packet on the output, grant locked
  logic last_win_q;
  logic pick;
  logic sel;

  // alternate only when both ports are waiting
  assign pick = (a_valid_i && b_valid_i) ? ~last_win_q : b_valid_i;
  assign sel  = busy_q ? grant_q : pick;

  assign beat_o    = sel ? b_beat_i : a_beat_i;
  assign valid_o   = sel ? b_valid_i : a_valid_i;
  assign a_ready_o = ready_i & ~sel;
  assign b_ready_o = ready_i & sel;

  always_ff @(posedge core_clk or negedge core_aresetn) begin
    if (!core_aresetn) begin
      grant_q    <= 1'b0;
      busy_q     <= 1'b0;
      last_win_q <= 1'b1;  // port a goes first
    end else if (valid_o) begin
      if (ready_i && beat_o.last) begin
        busy_q     <= 1'b0;
        last_win_q <= sel;
      end else begin
        // hold the choice while a beat is stalled or mid packet
        busy_q  <= 1'b1;
        grant_q <= sel;
      end
    end
  end

endmodule

/* test/tb_clk_gen.sv */
module tb_clk_gen (
  output logic core_clk_o,
  output logic core_aresetn_o
);

  localparam int HALF_PERIOD  = 5;
  localparam int RESET_CYCLES = 4;

  initial begin
    core_clk_o = 1'b0;
    forever #HALF_PERIOD core_clk_o = ~core_clk_o;
  end

  initial begin
    core_aresetn_o = 1'b0;
    repeat (RESET_CYCLES) @(posedge core_clk_o);
    core_aresetn_o <= 1'b1;  // released on an edge
  end

endmodule

/* test/tb_pkt_checker.sv */
`include "roce_consts.svh"

module tb_pkt_checker (
  input  logic                      core_clk,
  input  logic                      core_aresetn,
  input  logic                      cfg_done_i,
  input  tx_stream_pkg::local_cfg_t local_cfg_i,
  input  tx_stream_pkg::qp_entry_t  qp_tbl_i [`NUM_QP],
  input  tx_stream_pkg::wqe_desc_t  wqe_desc_i,
  input  logic                      wqe_valid_i,
  input  tx_stream_pkg::tx_beat_t   tx_beat_i,
  input  logic                      tx_valid_i,
  input  logic                      tx_ready_i,
  input  logic                      post_rd_wqe_i,
  input  logic                      post_wr_wqe_i,
  input  logic                      send_done_i,
  input  logic                      rd_done_i,
  input  logic                      wr_done_i,
  input  logic                      end_check_i,
  output int                        value_errs_o,
  output int                        proto_errs_o
);
  import tx_stream_pkg::*;

  localparam int MAX_BYTES = 5 * `BEAT_BYTES;

  // kind 0 send, 1 read response, 2 ack
  typedef struct packed {
    logic [1:0]             kind;
    logic [15:0]            len;
    logic [MAX_BYTES*8-1:0] bytes;  // byte n in [n*8 +: 8]
  } exp_pkt_t;

  exp_pkt_t   send_q[$];
  exp_pkt_t   resp_q[$];
  exp_pkt_t   cur;
  int         rx_cnt [3] = '{0, 0, 0};
  int         rd_posts = 0;
  int         wr_posts = 0;
  int         rd_descs = 0;
  int         beat_idx = 0;
  int         value_errs = 0;
  int         proto_errs = 0;
  logic       in_pkt = 1'b0;
  logic       cfg_seen = 1'b0;
  logic       outstanding = 1'b0;
  logic       stalled = 1'b0;
  logic       end_done = 1'b0;
  logic [2:0] done_prev = 3'b000;
  tx_beat_t   held_beat;

  assign value_errs_o = value_errs;
  assign proto_errs_o = proto_errs;

  task automatic value_error(input string sig, input logic [639:0] exp_v,
                             input logic [639:0] act_v);
    $display("ERROR at %0t: %s expected %0h, got %0h", $time, sig, exp_v, act_v);
    value_errs++;
  endtask

  task automatic protocol_error(input string msg);
    $display("ERROR at %0t: %s", $time, msg);
    proto_errs++;
  endtask

  function automatic exp_pkt_t build_pkt(
    input logic [1:0]  kind,
    input qp_entry_t   qp,
    input logic [15:0] total_len,
    input logic [7:0]  opcode,
    input logic [7:0]  bth_flags,
    input logic [23:0] qpn,
    input logic [23:0] psn,
    input int          pay_len,
    input logic [7:0]  pay_byte,
    input int          pkt_len
  );
    logic [7:0]  b [MAX_BYTES];
    logic [31:0] sum;
    exp_pkt_t    p;
    for (int i = 0; i < MAX_BYTES; i++) begin
      b[i] = 8'h00;
    end
    for (int i = 0; i < 6; i++) begin
      b[i]     = qp.dst_mac[47-8*i -: 8];
      b[6 + i] = local_cfg_i.src_mac[47-8*i -: 8];
    end
    {b[12], b[13]}               = `ETHERTYPE_IPV4;
    {b[14], b[15], b[16], b[17]} = {`IP_VER_IHL, `IP_TOS, total_len};
    {b[18], b[19], b[20], b[21]} = {`IP_IDENT, `IP_FLAGS};
    {b[22], b[23]}               = {`IP_TTL, `IP_PROTO_UDP};
    {b[26], b[27], b[28], b[29]} = local_cfg_i.src_ip;
    {b[30], b[31], b[32], b[33]} = qp.dst_ip;
    sum = 32'h0;
    for (int i = 14; i < 34; i += 2) begin
      sum = sum + {16'h0, b[i], b[i+1]};  // checksum word still zero here
    end
    while (sum[31:16] != 16'h0) begin
      sum = {16'h0, sum[15:0]} + {16'h0, sum[31:16]};
    end
    {b[24], b[25]}               = ~sum[15:0];
    {b[34], b[35], b[36], b[37]} = {`UDP_SRC_PORT, `UDP_DST_PORT};
    {b[38], b[39]}               = total_len - 16'd20;
    {b[42], b[43], b[44], b[45], b[46]} = {opcode, bth_flags, `BTH_PKEY, `BTH_RSVD};
    {b[47], b[48], b[49]}        = qpn;
    {b[51], b[52], b[53]}        = psn;
    for (int i = 0; i < pay_len; i++) begin
      b[pkt_len - pay_len + i] = pay_byte;
    end
    p.kind = kind;
    p.len  = 16'(pkt_len);
    for (int i = 0; i < MAX_BYTES; i++) begin
      p.bytes[i*8 +: 8] = b[i];
    end
    return p;
  endfunction

  function automatic logic [`BEAT_BYTES-1:0] exp_keep(input int rem);
    logic [`BEAT_BYTES-1:0] k;
    k = '0;
    for (int i = 0; i < `BEAT_BYTES; i++) begin
      if (i < rem) begin
        k[i] = 1'b1;
      end
    end
    return k;
  endfunction

  task automatic check_levels();
    if (!cfg_done_i && (tx_valid_i || post_rd_wqe_i || post_wr_wqe_i)) begin
      protocol_error("DUT active before cfg_done_i was set");
    end
    if (send_done_i && rx_cnt[0] < `NUM_SEND_PKT) begin
      protocol_error("send_done_o high before the last Send packet transferred");
    end
    if (rd_done_i && rx_cnt[1] < `NUM_RD_PKT) begin
      protocol_error("rd_done_o high before the last read response transferred");
    end
    if (wr_done_i && rx_cnt[2] < `NUM_WR_PKT) begin
      protocol_error("wr_done_o high before the last ACK transferred");
    end
    if ((done_prev & ~{wr_done_i, rd_done_i, send_done_i}) != 3'b000) begin
      protocol_error("a done flag fell after it was set");
    end
    done_prev = {wr_done_i, rd_done_i, send_done_i};
  endtask

  task automatic build_send_pkts();
    for (int k = 0; k < `NUM_SEND_PKT; k++) begin
      send_q.push_back(build_pkt(2'd0, qp_tbl_i[k % `NUM_QP], `SEND_TOTAL_LEN,
                                 `OP_SEND_ONLY, `SEND_BTH_FLAGS, 24'(k % `NUM_QP + 2),
                                 qp_tbl_i[k % `NUM_QP].base_psn + 24'(k / `NUM_QP + 1),
                                 `SEND_PAYLOAD_BYTES, 8'(k + 1), `SEND_PKT_BYTES));
    end
  endtask

  task automatic track_requests();
    logic [23:0] qpn;
    logic [23:0] psn;
    qp_entry_t   qp;
    if (post_rd_wqe_i) begin
      if (outstanding || wr_posts != 0 || rd_posts >= `NUM_RD_PKT) begin
        protocol_error("unexpected post_rd_wqe_o pulse");
      end
      rd_posts++;
      outstanding = 1'b1;
    end
    if (post_wr_wqe_i) begin
      if (outstanding || rx_cnt[1] != `NUM_RD_PKT || wr_posts >= `NUM_WR_PKT) begin
        protocol_error("unexpected post_wr_wqe_o pulse");
      end
      wr_posts++;
      outstanding = 1'b1;
    end
    if (wqe_valid_i) begin
      qpn = {wqe_desc_i.data[47*8 +: 8], wqe_desc_i.data[48*8 +: 8], wqe_desc_i.data[49*8 +: 8]};
      psn = {wqe_desc_i.data[51*8 +: 8], wqe_desc_i.data[52*8 +: 8], wqe_desc_i.data[53*8 +: 8]};
      qp  = qp_tbl_i[(int'(qpn) - 2) % `NUM_QP];
      if (wr_posts == 0) begin
        resp_q.push_back(build_pkt(2'd1, qp, `RD_TOTAL_LEN, `OP_RD_RESP_ONLY, 8'h00, qpn, psn,
                                   `RD_PAYLOAD_BYTES, 8'h10 + 8'((rd_descs + 1) % 16),
                                   `RD_PKT_BYTES));
        rd_descs++;
      end else begin
        resp_q.push_back(build_pkt(2'd2, qp, `ACK_TOTAL_LEN, `OP_ACK, 8'h00, qpn, psn,
                                   0, 8'h00, `ACK_PKT_BYTES));
      end
    end
  endtask

  task automatic compare_beat();
    logic [`BEAT_BYTES*8-1:0] mask;
    logic [`BEAT_BYTES*8-1:0] exp_data;
    logic [`BEAT_BYTES-1:0]   keep;
    int                       rem;
    if (!in_pkt) begin
      if (tx_beat_i.data[42*8 +: 8] == `OP_SEND_ONLY && send_q.size() > 0) begin
        cur = send_q.pop_front();
      end else if (tx_beat_i.data[42*8 +: 8] != `OP_SEND_ONLY && resp_q.size() > 0) begin
        cur = resp_q.pop_front();
      end else begin
        protocol_error("a beat transferred while no packet of its kind was expected");
        return;
      end
      in_pkt   = 1'b1;
      beat_idx = 0;
    end
    rem      = int'(cur.len) - beat_idx * `BEAT_BYTES;
    keep     = exp_keep(rem);
    exp_data = cur.bytes[beat_idx*`BEAT_BYTES*8 +: `BEAT_BYTES*8];
    for (int i = 0; i < `BEAT_BYTES; i++) begin
      mask[i*8 +: 8] = {8{keep[i]}};
    end
    // bytes past keep are not part of the packet
    if ((tx_beat_i.data & mask) != (exp_data & mask)) begin
      value_error("tx_beat_o.data", 640'(exp_data & mask), 640'(tx_beat_i.data & mask));
    end
    if (tx_beat_i.keep != keep) begin
      value_error("tx_beat_o.keep", 640'(keep), 640'(tx_beat_i.keep));
    end
    if (tx_beat_i.last != (rem <= `BEAT_BYTES)) begin
      value_error("tx_beat_o.last", 640'(rem <= `BEAT_BYTES), 640'(tx_beat_i.last));
    end
    beat_idx++;
    if (rem <= `BEAT_BYTES) begin
      in_pkt = 1'b0;
      rx_cnt[cur.kind]++;
      if (cur.kind != 2'd0) begin
        outstanding = 1'b0;
      end
    end
  endtask

  task automatic final_check();
    if (send_q.size() != 0 || resp_q.size() != 0 || in_pkt) begin
      protocol_error("expected packets never came out of the DUT");
    end
    if (rx_cnt[0] != `NUM_SEND_PKT || rx_cnt[1] != `NUM_RD_PKT || rx_cnt[2] != `NUM_WR_PKT) begin
      protocol_error("number of packets per kind is wrong");
    end
    if (rd_posts != `NUM_RD_PKT || wr_posts != `NUM_WR_PKT) begin
      protocol_error("number of work request pulses is wrong");
    end
  endtask

  always @(posedge core_clk) begin
    if (!core_aresetn) begin
      if (tx_valid_i || post_rd_wqe_i || post_wr_wqe_i || send_done_i || rd_done_i || wr_done_i) begin
        protocol_error("DUT outputs not low during reset");
      end
    end else begin
      check_levels();
      if (cfg_done_i && !cfg_seen) begin
        cfg_seen = 1'b1;  // table is static from here on
        build_send_pkts();
      end
      track_requests();
      if (stalled && !tx_valid_i) begin
        protocol_error("tx_valid_o dropped before its beat transferred");
      end else if (stalled && tx_beat_i != held_beat) begin
        value_error("tx_beat_o", 640'(held_beat), 640'(tx_beat_i));
      end
      stalled   = tx_valid_i && !tx_ready_i;
      held_beat = tx_beat_i;
      if (tx_valid_i && tx_ready_i) begin
        compare_beat();
      end
      if (end_check_i && !end_done) begin
        end_done = 1'b1;
        final_check();
      end
    end
  end

endmodule

/* test/tb_roce_tx_top.sv */
`include "roce_consts.svh"

module tb_roce_tx_top;
  import tx_stream_pkg::*;

  localparam int TIMEOUT_CYCLES = (`NUM_SEND_PKT + `NUM_RD_PKT + `NUM_WR_PKT) * 2000;

  logic       core_clk;
  logic       core_aresetn;
  logic       cfg_done;
  local_cfg_t local_cfg;
  qp_entry_t  qp_tbl [`NUM_QP];
  wqe_desc_t  wqe_desc;
  logic       wqe_valid;
  tx_beat_t   tx_beat;
  logic       tx_valid;
  logic       tx_ready;
  logic       post_rd_wqe;
  logic       post_wr_wqe;
  logic       send_done;
  logic       rd_done;
  logic       wr_done;
  logic       end_check;
  int         value_errs;
  int         proto_errs;
  integer     seed = 32'h786c1b2e;

  tb_clk_gen i_clk_gen (
    .core_clk_o     (core_clk),
    .core_aresetn_o (core_aresetn)
  );

  roce_tx_top i_roce_tx_top (
    .core_clk      (core_clk),
    .core_aresetn  (core_aresetn),
    .cfg_done_i    (cfg_done),
    .local_cfg_i   (local_cfg),
    .qp_tbl_i      (qp_tbl),
    .wqe_desc_i    (wqe_desc),
    .wqe_valid_i   (wqe_valid),
    .tx_beat_o     (tx_beat),
    .tx_valid_o    (tx_valid),
    .tx_ready_i    (tx_ready),
    .post_rd_wqe_o (post_rd_wqe),
    .post_wr_wqe_o (post_wr_wqe),
    .send_done_o   (send_done),
    .rd_done_o     (rd_done),
    .wr_done_o     (wr_done)
  );

  tb_pkt_checker i_pkt_checker (
    .core_clk      (core_clk),
    .core_aresetn  (core_aresetn),
    .cfg_done_i    (cfg_done),
    .local_cfg_i   (local_cfg),
    .qp_tbl_i      (qp_tbl),
    .wqe_desc_i    (wqe_desc),
    .wqe_valid_i   (wqe_valid),
    .tx_beat_i     (tx_beat),
    .tx_valid_i    (tx_valid),
    .tx_ready_i    (tx_ready),
    .post_rd_wqe_i (post_rd_wqe),
    .post_wr_wqe_i (post_wr_wqe),
    .send_done_i   (send_done),
    .rd_done_i     (rd_done),
    .wr_done_i     (wr_done),
    .end_check_i   (end_check),
    .value_errs_o  (value_errs),
    .proto_errs_o  (proto_errs)
  );

  task automatic random_delay(input int max_cycles);
    int n;
    n = {$random(seed)} % (max_cycles + 1);
    repeat (n) @(posedge core_clk);
  endtask

  initial begin : main_seq
    cfg_done  = 1'b0;
    local_cfg = '0;
    wqe_desc  = '0;
    wqe_valid = 1'b0;
    tx_ready  = 1'b0;
    end_check = 1'b0;
    for (int q = 0; q < `NUM_QP; q++) begin
      qp_tbl[q] = '0;
    end
    @(posedge core_aresetn);
    @(posedge core_clk);
    local_cfg <= '{src_mac: 48'({$random(seed), $random(seed)}), src_ip: $random(seed)};
    for (int q = 0; q < `NUM_QP; q++) begin
      qp_tbl[q] <= '{dst_mac: 48'({$random(seed), $random(seed)}), dst_ip: $random(seed),
                     base_psn: 24'($random(seed))};
    end
    random_delay(20);
    @(posedge core_clk);
    cfg_done <= 1'b1;
    wait (send_done && rd_done && wr_done);
    repeat (20) @(posedge core_clk);  // catch stray packets
    end_check <= 1'b1;
    repeat (2) @(posedge core_clk);
    $display("error counts: %0d wrong values, %0d protocol errors", value_errs, proto_errs);
    if (value_errs == 0 && proto_errs == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

  initial begin : ready_drive
    @(posedge core_aresetn);
    forever begin
      @(posedge core_clk);
      tx_ready <= (($random(seed) & 3) != 0);  // high about 3 cycles in 4
    end
  end

  // one descriptor beat per post pulse
  initial begin : desc_drive
    logic [23:0]              qpn;
    logic [23:0]              psn;
    logic [`BEAT_BYTES*8-1:0] data;
    forever begin
      @(posedge core_clk);
      if (post_rd_wqe || post_wr_wqe) begin
        random_delay(15);
        for (int w = 0; w < `BEAT_BYTES / 4; w++) begin
          data[w*32 +: 32] = $random(seed);
        end
        qpn = 24'(2 + {$random(seed)} % `NUM_QP);
        psn = 24'($random(seed));
        {data[47*8 +: 8], data[48*8 +: 8], data[49*8 +: 8]} = qpn;
        {data[51*8 +: 8], data[52*8 +: 8], data[53*8 +: 8]} = psn;
        wqe_desc  <= '{data: data, last: 1'b1};
        wqe_valid <= 1'b1;
        @(posedge core_clk);
        wqe_valid <= 1'b0;
      end
    end
  end

  initial begin : watchdog
    repeat (TIMEOUT_CYCLES) @(posedge core_clk);
    $display("timeout: the DUT did not finish all packets within %0d cycles", TIMEOUT_CYCLES);
    $display("error counts: %0d wrong values, %0d protocol errors", value_errs, proto_errs);
    $display("Test failed");
    $finish;
  end

endmodule
